// File: verilog/cpu_cfg.svh
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// Address of the first instruction fetch
`define RESET_PC 32'h0000_0000

// General registers, zero register included
`define REG_COUNT 32

`endif

// File: verilog/isa_pkg.sv
package isa_pkg;

	// Primary opcode field
	localparam logic [5:0] opc_special = 6'h00;
	localparam logic [5:0] opc_j       = 6'h02;
	localparam logic [5:0] opc_beq     = 6'h04;
	localparam logic [5:0] opc_bne     = 6'h05;
	localparam logic [5:0] opc_addiu   = 6'h09;
	localparam logic [5:0] opc_ori     = 6'h0d;
	localparam logic [5:0] opc_lui     = 6'h0f;
	localparam logic [5:0] opc_lw      = 6'h23;
	localparam logic [5:0] opc_sw      = 6'h2b;

	// Funct field of SPECIAL
	localparam logic [5:0] fn_addu = 6'h21;
	localparam logic [5:0] fn_subu = 6'h23;
	localparam logic [5:0] fn_and  = 6'h24;
	localparam logic [5:0] fn_or   = 6'h25;
	localparam logic [5:0] fn_slt  = 6'h2a;

	// Zero must stay the nop, bubbles rely on it
	typedef enum logic [4:0] {
		op_nop, op_addu, op_subu, op_and, op_or, op_slt, op_lui,
		op_lw, op_sw, op_beq, op_bne, op_j
	} op_t;

endpackage

// File: verilog/cpu_types_pkg.sv
package cpu_types_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_addr_t;

	typedef struct packed {
		word_t pc;
		word_t inst;
	} if_id_t;

	typedef struct packed {
		isa_pkg::op_t op;
		word_t        a;
		word_t        b;
		word_t        store_data;
		reg_addr_t    dest;
		logic         we;
	} id_ex_t;

	// Dest of zero means no register write
	typedef struct packed {
		isa_pkg::op_t op;
		word_t        result;
		word_t        store_data;
		reg_addr_t    dest;
	} ex_mem_t;

	typedef struct packed {
		logic      we;
		reg_addr_t dest;
		word_t     wdata;
	} mem_wb_t;

endpackage

// File: verilog/regs.sv
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module regs (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     we,
	input  cpu_types_pkg::reg_addr_t waddr,
	input  cpu_types_pkg::word_t     wdata,
	input  cpu_types_pkg::reg_addr_t raddr1,
	input  cpu_types_pkg::reg_addr_t raddr2,
	output cpu_types_pkg::word_t     rdata1,
	output cpu_types_pkg::word_t     rdata2
);
	import cpu_types_pkg::*;

	word_t rf [`REG_COUNT];

	// Write in flight wins over the stored value
	function automatic word_t read_port(reg_addr_t addr);
		if (addr == '0)
			return '0;
		if (we && waddr == addr)
			return wdata;
		return rf[addr];
	endfunction

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `REG_COUNT; i++)
				rf[i] <= '0;
		end else if (we && waddr != '0) begin
			rf[waddr] <= wdata;
		end
	end

	always_comb begin
		rdata1 = read_port(raddr1);
		rdata2 = read_port(raddr2);
	end

	// A write aimed at register 0 never reaches a read port
	assert property (@(posedge clk) disable iff (reset)
		we && waddr == '0 |-> (raddr1 != '0 || rdata1 == '0) && (raddr2 != '0 || rdata2 == '0));

endmodule

// File: verilog/stage_reg.sv
`timescale 1ns/1ps

module stage_reg #(
	parameter type payload_t = logic [31:0]
) (
	input  logic     clk,
	input  logic     reset,
	input  logic     hold,
	input  logic     bubble,
	input  payload_t d,
	output payload_t q
);

	// All-zero payload is a nop with no write
	always_ff @(posedge clk) begin
		if (reset || bubble)
			q <= '0;
		else if (!hold)
			q <= d;
	end

	// Controller picks one or the other per stage
	assert property (@(posedge clk) disable iff (reset) !(hold && bubble));

endmodule

// File: verilog/cpu_if.sv
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module cpu_if (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 hold,
	input  logic                 jump,
	input  cpu_types_pkg::word_t jump_to,
	input  logic                 inst_stall,
	output logic                 inst_read,
	output cpu_types_pkg::word_t inst_addr,
	output cpu_types_pkg::word_t pc,
	output logic                 stall_from_if
);
	import cpu_types_pkg::*;

	word_t next_pc;

	// Branch in ID redirects after its delay slot fetch
	assign next_pc = jump ? jump_to : pc + 32'd4;

	always_ff @(posedge clk) begin
		if (reset)
			pc <= `RESET_PC;
		else if (!hold)
			pc <= next_pc;
	end

	assign inst_read     = 1'b1;
	assign inst_addr     = pc;
	assign stall_from_if = inst_read && inst_stall;

endmodule

// File: verilog/cpu_id.sv
`timescale 1ns/1ps

module cpu_id (
	input  cpu_types_pkg::word_t     inst,
	input  cpu_types_pkg::word_t     pc,
	input  cpu_types_pkg::word_t     rdata1,
	input  cpu_types_pkg::word_t     rdata2,
	output cpu_types_pkg::reg_addr_t raddr1,
	output cpu_types_pkg::reg_addr_t raddr2,
	input  isa_pkg::op_t             ex_op,
	input  cpu_types_pkg::reg_addr_t ex_dest,
	input  cpu_types_pkg::word_t     ex_result,
	input  logic                     mem_we,
	input  cpu_types_pkg::reg_addr_t mem_dest,
	input  cpu_types_pkg::word_t     mem_result,
	output cpu_types_pkg::id_ex_t    id_out,
	output logic                     jump,
	output cpu_types_pkg::word_t     jump_to,
	output logic                     stall_from_id
);
	import isa_pkg::*;
	import cpu_types_pkg::*;

	logic [5:0] opcode;
	logic [5:0] funct;
	reg_addr_t  rs, rt, rd;
	word_t      imm_sext, imm_zext, delay_pc, src1, src2;

	assign opcode   = inst[31:26];
	assign funct    = inst[5:0];
	assign rs       = inst[25:21];
	assign rt       = inst[20:16];
	assign rd       = inst[15:11];
	assign imm_sext = {{16{inst[15]}}, inst[15:0]};
	assign imm_zext = {16'h0, inst[15:0]};
	assign delay_pc = pc + 32'd4;
	assign raddr1   = rs;
	assign raddr2   = rt;

	// Youngest producer first
	function automatic word_t forward(reg_addr_t addr, word_t rf_value);
		if (addr == '0)
			return '0;
		if (ex_dest == addr)
			return ex_result;
		if (mem_we && mem_dest == addr)
			return mem_result;
		return rf_value;
	endfunction

	// Load result not ready until MEM
	assign stall_from_id = ex_op == op_lw && ex_dest != '0 && (ex_dest == rs || ex_dest == rt);

	always_comb begin
		src1              = forward(rs, rdata1);
		src2              = forward(rt, rdata2);
		id_out            = '0;
		id_out.a          = src1;
		id_out.b          = src2;
		id_out.store_data = src2;
		jump              = 1'b0;
		jump_to           = delay_pc + {imm_sext[29:0], 2'b00};
		case (opcode)
			opc_special: begin
				id_out.dest = rd;
				id_out.we   = 1'b1;
				case (funct)
					fn_addu: id_out.op = op_addu;
					fn_subu: id_out.op = op_subu;
					fn_and:  id_out.op = op_and;
					fn_or:   id_out.op = op_or;
					fn_slt:  id_out.op = op_slt;
					default: id_out.we = 1'b0;
				endcase
			end
			opc_addiu, opc_lw: begin
				id_out.op   = opcode == opc_lw ? op_lw : op_addu;
				id_out.b    = imm_sext;
				id_out.dest = rt;
				id_out.we   = 1'b1;
			end
			opc_ori, opc_lui: begin
				id_out.op   = opcode == opc_lui ? op_lui : op_or;
				id_out.b    = imm_zext;
				id_out.dest = rt;
				id_out.we   = 1'b1;
			end
			opc_sw: begin
				id_out.op = op_sw;
				id_out.b  = imm_sext;
			end
			opc_beq: begin
				id_out.op = op_beq;
				jump      = src1 == src2;
			end
			opc_bne: begin
				id_out.op = op_bne;
				jump      = src1 != src2;
			end
			opc_j: begin
				id_out.op = op_j;
				jump      = 1'b1;
				jump_to   = {delay_pc[31:28], inst[25:0], 2'b00};
			end
			default: ;
		endcase
	end

endmodule

// File: verilog/cpu_ex.sv
`timescale 1ns/1ps

module cpu_ex (
	input  cpu_types_pkg::id_ex_t  ex_in,
	output cpu_types_pkg::ex_mem_t ex_out
);
	import isa_pkg::*;
	import cpu_types_pkg::*;

	always_comb begin
		ex_out.op         = ex_in.op;
		ex_out.store_data = ex_in.store_data;
		ex_out.dest       = ex_in.we ? ex_in.dest : '0;
		case (ex_in.op)
			// Loads and stores use the adder for the address
			op_addu, op_lw, op_sw: ex_out.result = ex_in.a + ex_in.b;
			op_subu:               ex_out.result = ex_in.a - ex_in.b;
			op_and:                ex_out.result = ex_in.a & ex_in.b;
			op_or:                 ex_out.result = ex_in.a | ex_in.b;
			op_slt:                ex_out.result = word_t'($signed(ex_in.a) < $signed(ex_in.b));
			op_lui:                ex_out.result = {ex_in.b[15:0], 16'h0};
			default:               ex_out.result = '0;
		endcase
	end

endmodule

// File: verilog/cpu_mem.sv
`timescale 1ns/1ps

module cpu_mem (
	input  cpu_types_pkg::ex_mem_t mem_in,
	input  logic                   data_stall,
	input  cpu_types_pkg::word_t   data_rdata,
	output logic                   data_read,
	output logic                   data_write,
	output cpu_types_pkg::word_t   data_addr,
	output cpu_types_pkg::word_t   data_wdata,
	output cpu_types_pkg::mem_wb_t wb_out,
	output logic                   stall_from_mem
);
	import isa_pkg::*;

	assign data_read      = mem_in.op == op_lw;
	assign data_write     = mem_in.op == op_sw;
	assign data_addr      = mem_in.result;
	assign data_wdata     = mem_in.store_data;
	assign stall_from_mem = (data_read || data_write) && data_stall;

	// Load data is valid in the completion cycle only
	assign wb_out.we    = mem_in.dest != '0;
	assign wb_out.dest  = mem_in.dest;
	assign wb_out.wdata = data_read ? data_rdata : mem_in.result;

	always_comb begin
		if (data_read || data_write) begin
			assert (data_addr[1:0] == 2'b00)
			else $error("unaligned data access at %h", data_addr);
		end
	end

endmodule

// File: verilog/ctrl.sv
`timescale 1ns/1ps

module ctrl (
	input  logic stall_from_if,
	input  logic stall_from_id,
	input  logic stall_from_mem,
	output logic hold_if,
	output logic hold_id,
	output logic hold_ex,
	output logic hold_mem,
	output logic bubble_ex,
	output logic bubble_wb
);

	always_comb begin
		hold_if   = 1'b0;
		hold_id   = 1'b0;
		hold_ex   = 1'b0;
		hold_mem  = 1'b0;
		bubble_ex = 1'b0;
		bubble_wb = 1'b0;
		if (stall_from_mem) begin
			hold_if   = 1'b1;
			hold_id   = 1'b1;
			hold_ex   = 1'b1;
			hold_mem  = 1'b1;
			bubble_wb = 1'b1;
		end else if (stall_from_id || stall_from_if) begin
			// ID waits with its instruction, EX runs empty
			hold_if   = 1'b1;
			hold_id   = 1'b1;
			bubble_ex = 1'b1;
		end
	end

endmodule

// File: verilog/trivial_mips.sv
`timescale 1ns/1ps

module trivial_mips (
	input  logic                 clk,
	input  logic                 reset,
	output logic                 inst_read,
	output cpu_types_pkg::word_t inst_addr,
	input  cpu_types_pkg::word_t inst_rdata,
	input  logic                 inst_stall,
	output logic                 data_read,
	output logic                 data_write,
	output cpu_types_pkg::word_t data_addr,
	output cpu_types_pkg::word_t data_wdata,
	input  cpu_types_pkg::word_t data_rdata,
	input  logic                 data_stall
);
	import cpu_types_pkg::*;

	logic      hold_if, hold_id, hold_ex, hold_mem, bubble_ex, bubble_wb;
	logic      stall_from_if, stall_from_id, stall_from_mem;
	logic      jump, if_read, fetch_valid;
	word_t     jump_to, if_pc, fetch_inst, if_inst;
	reg_addr_t reg_raddr1, reg_raddr2;
	word_t     reg_rdata1, reg_rdata2;
	if_id_t    if_d, id_q;
	id_ex_t    id_d, ex_q;
	ex_mem_t   ex_d, mem_q;
	mem_wb_t   mem_d, wb_q;

	// Fetch finished while IF is held, keep it until IF moves
	always_ff @(posedge clk) begin
		if (reset || !hold_if)
			fetch_valid <= 1'b0;
		else if (inst_read && !inst_stall)
			fetch_valid <= 1'b1;
	end

	always_ff @(posedge clk) begin
		if (inst_read && !inst_stall)
			fetch_inst <= inst_rdata;
	end

	assign inst_read = if_read && !fetch_valid;
	assign if_inst   = fetch_valid ? fetch_inst : inst_rdata;
	assign if_d      = '{pc: if_pc, inst: if_inst};

	regs general_regs_instance(
		.clk, .reset,
		.we(wb_q.we), .waddr(wb_q.dest), .wdata(wb_q.wdata),
		.raddr1(reg_raddr1), .raddr2(reg_raddr2),
		.rdata1(reg_rdata1), .rdata2(reg_rdata2)
	);

	ctrl ctrl_instance(
		.stall_from_if, .stall_from_id, .stall_from_mem,
		.hold_if, .hold_id, .hold_ex, .hold_mem, .bubble_ex, .bubble_wb
	);

	cpu_if stage_if(
		.clk, .reset, .hold(hold_if), .jump, .jump_to,
		.inst_stall(inst_stall && !fetch_valid), .inst_read(if_read),
		.inst_addr, .pc(if_pc), .stall_from_if
	);

	stage_reg #(.payload_t(if_id_t)) if_id(
		.clk, .reset, .hold(hold_id), .bubble(1'b0), .d(if_d), .q(id_q)
	);

	cpu_id stage_id(
		.inst(id_q.inst), .pc(id_q.pc),
		.rdata1(reg_rdata1), .rdata2(reg_rdata2),
		.raddr1(reg_raddr1), .raddr2(reg_raddr2),
		.ex_op(ex_d.op), .ex_dest(ex_d.dest), .ex_result(ex_d.result),
		.mem_we(mem_d.we), .mem_dest(mem_d.dest), .mem_result(mem_d.wdata),
		.id_out(id_d), .jump, .jump_to, .stall_from_id
	);

	stage_reg #(.payload_t(id_ex_t)) id_ex(
		.clk, .reset, .hold(hold_ex), .bubble(bubble_ex), .d(id_d), .q(ex_q)
	);

	cpu_ex stage_ex(.ex_in(ex_q), .ex_out(ex_d));

	stage_reg #(.payload_t(ex_mem_t)) ex_mem(
		.clk, .reset, .hold(hold_mem), .bubble(1'b0), .d(ex_d), .q(mem_q)
	);

	cpu_mem stage_mem(
		.mem_in(mem_q), .data_stall, .data_rdata,
		.data_read, .data_write, .data_addr, .data_wdata,
		.wb_out(mem_d), .stall_from_mem
	);

	stage_reg #(.payload_t(mem_wb_t)) mem_wb(
		.clk, .reset, .hold(1'b0), .bubble(bubble_wb), .d(mem_d), .q(wb_q)
	);

endmodule

// File: tests/tb_trivial_mips.sv
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module tb_trivial_mips;
	import isa_pkg::*;
	import cpu_types_pkg::*;

	localparam int prog_len   = 200;
	localparam int rand_len   = 182;
	localparam int end_idx    = rand_len + 16;
	localparam int max_cycles = prog_len * 12;

	logic  clk, reset;
	logic  inst_read, inst_stall, data_read, data_write, data_stall;
	word_t inst_addr, inst_rdata, data_addr, data_wdata, data_rdata;

	word_t       rom [256];
	word_t       ram [64];
	word_t       model_ram [64];
	word_t       model_regs [`REG_COUNT];
	word_t       exp_addr [$];
	word_t       exp_data [$];
	logic [31:0] rand_state;
	int          value_errors, other_errors, store_count, expected_stores;
	int          end_fetches, cycles;
	logic        first_fetch_seen, mem_op_fetched;

	trivial_mips i_trivial_mips(
		.clk, .reset, .inst_read, .inst_addr, .inst_rdata, .inst_stall,
		.data_read, .data_write, .data_addr, .data_wdata, .data_rdata, .data_stall
	);

	function automatic int unsigned draw(int unsigned n);
		rand_state = rand_state * 32'd1103515245 + 32'd12345;
		return (rand_state >> 16) % n;
	endfunction

	function automatic reg_addr_t some_reg();
		return reg_addr_t'(draw(16));
	endfunction

	function automatic word_t rtype_word(logic [5:0] fn, reg_addr_t rd, reg_addr_t rs,
			reg_addr_t rt);
		return {opc_special, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic word_t itype_word(logic [5:0] opc, reg_addr_t rt, reg_addr_t rs,
			logic [15:0] imm);
		return {opc, rs, rt, imm};
	endfunction

	function automatic word_t alu_word();
		reg_addr_t a, b, c;
		a = some_reg();
		b = some_reg();
		c = some_reg();
		case (draw(8))
			0: return rtype_word(fn_addu, a, b, c);
			1: return rtype_word(fn_subu, a, b, c);
			2: return rtype_word(fn_and, a, b, c);
			3: return rtype_word(fn_or, a, b, c);
			4: return rtype_word(fn_slt, a, b, c);
			5: return itype_word(opc_addiu, a, b, 16'(draw(65536)));
			6: return itype_word(opc_ori, a, b, 16'(draw(65536)));
			default: return itype_word(opc_lui, a, 5'd0, 16'(draw(65536)));
		endcase
	endfunction

	task automatic build_program();
		int i, kind, t;
		reg_addr_t r, s;
		i = 0;
		while (i < rand_len) begin
			kind = draw(16);
			r = some_reg();
			s = draw(4) == 0 ? r : some_reg();
			if (kind >= 12 && i + 5 <= rand_len) begin
				// Forward target past the delay slot
				t = i + 2 + draw(4);
				if (kind == 12)
					rom[i] = itype_word(opc_beq, s, r, 16'(t - i - 1));
				else if (kind == 13)
					rom[i] = itype_word(opc_bne, s, r, 16'(t - i - 1));
				else
					rom[i] = {opc_j, 26'(t)};
				rom[i + 1] = alu_word();
				i += 2;
			end else if (kind == 11 && i + 2 <= rand_len) begin
				// Load then an immediate user of it
				rom[i] = itype_word(opc_lw, r, 5'd0, 16'(draw(64) * 4));
				if (draw(2) == 0)
					rom[i + 1] = rtype_word(fn_addu, some_reg(), r, s);
				else
					rom[i + 1] = rtype_word(fn_subu, some_reg(), s, r);
				i += 2;
			end else begin
				if (kind == 9)
					rom[i] = itype_word(opc_lw, r, 5'd0, 16'(draw(64) * 4));
				else if (kind == 10)
					rom[i] = itype_word(opc_sw, r, 5'd0, 16'(draw(64) * 4));
				else
					rom[i] = alu_word();
				i++;
			end
		end
		for (int k = 0; k < 16; k++)
			rom[rand_len + k] = itype_word(opc_sw, reg_addr_t'(k), 5'd0, 16'(k * 4));
		rom[end_idx] = {opc_j, 26'(end_idx)};
	endtask

	// Reference execution, branch takes effect after its delay slot
	task automatic run_model();
		int pc, npc, next, steps;
		word_t inst, a, b, imm_s, ea, res;
		logic wr;
		reg_addr_t dst;
		pc = 0;
		npc = 1;
		steps = 0;
		for (int k = 0; k < `REG_COUNT; k++)
			model_regs[k] = '0;
		while (pc != end_idx && steps < 10 * prog_len) begin
			inst = rom[pc];
			a = model_regs[inst[25:21]];
			b = model_regs[inst[20:16]];
			imm_s = {{16{inst[15]}}, inst[15:0]};
			ea = a + imm_s;
			next = npc + 1;
			wr = 1'b1;
			dst = inst[20:16];
			res = '0;
			case (inst[31:26])
				opc_special: begin
					dst = inst[15:11];
					case (inst[5:0])
						fn_addu: res = a + b;
						fn_subu: res = a - b;
						fn_and:  res = a & b;
						fn_or:   res = a | b;
						fn_slt:  res = {31'd0, $signed(a) < $signed(b)};
						default: wr = 1'b0;
					endcase
				end
				opc_addiu: res = a + imm_s;
				opc_ori:   res = a | {16'd0, inst[15:0]};
				opc_lui:   res = {inst[15:0], 16'd0};
				opc_lw:    res = model_ram[ea[7:2]];
				opc_sw: begin
					wr = 1'b0;
					exp_addr.push_back(ea);
					exp_data.push_back(b);
					model_ram[ea[7:2]] = b;
				end
				opc_beq: begin
					wr = 1'b0;
					if (a == b)
						next = npc + int'($signed(inst[15:0]));
				end
				opc_bne: begin
					wr = 1'b0;
					if (a != b)
						next = npc + int'($signed(inst[15:0]));
				end
				opc_j: begin
					wr = 1'b0;
					next = int'(inst[25:0]);
				end
				default: wr = 1'b0;
			endcase
			if (wr && dst != '0)
				model_regs[dst] = res;
			pc = npc;
			npc = next;
			steps++;
		end
	endtask

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("error at %0t: %s got %h expected %h", $time, name, got, exp);
			value_errors++;
		end
	endtask

	task automatic check_count(input int got, input int exp);
		if (got != exp) begin
			$display("error at %0t: store count got %0d expected %0d", $time, got, exp);
			value_errors++;
		end
	endtask

	// Both memories, called once per falling edge
	task automatic serve_buses();
		if (data_read && data_write) begin
			$display("error at %0t: data_read and data_write are both high", $time);
			other_errors++;
		end
		if ((data_read || data_write) && !mem_op_fetched) begin
			$display("error at %0t: data access before any lw or sw was fetched", $time);
			other_errors++;
		end
		data_stall = (data_read || data_write) && draw(4) == 0;
		data_rdata = data_stall ? word_t'(draw(65536)) : ram[data_addr[7:2]];
		if (data_write && !data_stall) begin
			if (exp_addr.size() == 0) begin
				$display("error at %0t: store to %h beyond the expected stream", $time,
					data_addr);
				other_errors++;
			end else begin
				check_word("data_addr", data_addr, exp_addr.pop_front());
				check_word("data_wdata", data_wdata, exp_data.pop_front());
			end
			ram[data_addr[7:2]] = data_wdata;
			store_count++;
		end
		inst_stall = inst_read && draw(4) == 0;
		inst_rdata = inst_stall ? word_t'(draw(65536)) : rom[inst_addr[9:2]];
		if (inst_read && !inst_stall) begin
			if (!first_fetch_seen)
				check_word("inst_addr", inst_addr, `RESET_PC);
			first_fetch_seen = 1'b1;
			if (inst_rdata[31:26] == opc_lw || inst_rdata[31:26] == opc_sw)
				mem_op_fetched = 1'b1;
			if (inst_addr == word_t'(end_idx * 4))
				end_fetches++;
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	initial begin
		reset = 1'b1;
		inst_stall = 1'b0;
		data_stall = 1'b0;
		inst_rdata = '0;
		data_rdata = '0;
		rand_state = 32'h786e;
		value_errors = 0;
		other_errors = 0;
		store_count = 0;
		end_fetches = 0;
		cycles = 0;
		first_fetch_seen = 1'b0;
		mem_op_fetched = 1'b0;
		for (int k = 0; k < 256; k++)
			rom[k] = '0;
		for (int k = 0; k < 64; k++) begin
			ram[k] = (word_t'(k) * 32'h9e37_79b9) ^ 32'h5a5a_0000;
			model_ram[k] = ram[k];
		end
		build_program();
		run_model();
		expected_stores = exp_addr.size();
		repeat (4) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		// Third fetch of the self-jump means every store has left MEM
		while (end_fetches < 3 && cycles < max_cycles) begin
			serve_buses();
			@(negedge clk);
			cycles++;
		end
		if (end_fetches < 3) begin
			$display("timeout after %0d cycles, the program never reached its final self-jump",
				cycles);
			other_errors++;
		end else begin
			check_count(store_count, expected_stores);
		end
		$display("%0d value errors, %0d other errors", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// File: all.f
+incdir+verilog
verilog/isa_pkg.sv
verilog/cpu_types_pkg.sv
verilog/regs.sv
verilog/stage_reg.sv
verilog/cpu_if.sv
verilog/cpu_id.sv
verilog/cpu_ex.sv
verilog/cpu_mem.sv
verilog/ctrl.sv
verilog/trivial_mips.sv
tests/tb_trivial_mips.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_trivial_mips -f all.f

out=$(./obj_dir/Vtb_trivial_mips)
echo "$out"

if echo "$out" | grep -qx "Test passed"; then
	exit 0
fi
exit 1
